/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mic
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cond_if.sv */
`default_nettype none

// latched condition fields, condition register to sequencer and loop counter.
interface cond_if;

  logic [3:0] tsel;     // decoded test select.
  logic [3:0] fs;       // alu function select.
  logic [3:0] lcc;      // loop counter control.
  logic       acond_n;  // low inverts the selected test.

  modport src (output tsel, output fs, output lcc, output acond_n);

  modport seq (input tsel, input acond_n);  // test mux side.

  modport cnt (input lcc);  // loop counter side.

endinterface

`default_nettype wire

/* cond_reg.sv */
`default_nettype none

module cond_reg (
  input  logic                mclk,
  input  logic                arst_n,
  input  mic_pkg::cond_field_u cs_field,
  input  logic                cscond,
  input  logic                lcs_n,
  cond_if.src                 cond
);

  import mic_pkg::*;

  cond_field_u field_q;    // latched condition bits.
  logic [3:0]  raw;        // latched test select, ungated.
  logic [3:0]  tsel;       // gated test select.
  logic        t_differ;   // tsel bits 2 and 1 disagree.
  logic        t_onezero;  // tsel bit 1 high with bit 0 low.

  // ----------------------------------------
  // condition flip-flops.
  // ----------------------------------------
  // twelve enabled flops, they recirculate unless cscond is high.
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      field_q <= '0;
    end else if (cscond) begin
      field_q <= cs_field;  // take the field at the end of the ldcond cycle.
    end
  end

  assign raw = field_q.cond.tsel_raw;

  // ----------------------------------------
  // test select decode.
  // ----------------------------------------
  // lcs_n low forces the select towards the unconditional group.
  assign tsel[3] = ~(lcs_n & raw[3]);  // high unless both are set.
  assign tsel[2] = lcs_n & raw[2];
  assign tsel[1] = lcs_n & raw[1];
  assign tsel[0] = lcs_n & raw[0];

  // a-condition, low means the test result is inverted.
  assign t_differ  = tsel[2] ^ tsel[1];
  assign t_onezero = tsel[1] & ~tsel[0];
  assign cond.acond_n = ~(tsel[3] & (t_differ | t_onezero));

  // outputs to the rest of the slice.
  assign cond.tsel = tsel;
  assign cond.fs   = field_q.cond.fs;   // only goes out as alu_fs.
  assign cond.lcc  = field_q.cond.lcc;  // held until the next strobe.

  // ----------------------------------------
  // checks.
  // ----------------------------------------
  // the held field may only move on the edge after a cscond cycle.
  a_field_hold : assert property (
    @(posedge mclk) disable iff (!arst_n)
      !$past(cscond) |-> $stable(field_q)
  );

endmodule

`default_nettype wire

/* control_store.sv */
`default_nettype none

module control_store (
  input  logic [mic_pkg::uaddr_w-1:0] upc,
  output logic [mic_pkg::uword_w-1:0] uword
);

  import mic_pkg::*;

  localparam int depth = 2 ** uaddr_w;  // 256 microwords.

  logic [uword_w-1:0] rom [depth];

  // words missing from the image stay zero, which runs as op_next.
  initial begin
    for (int i = 0; i < depth; i++) begin
      rom[i] = '0;
    end
    $readmemh("ucode.hex", rom);
  end

  assign uword = rom[upc];  // asynchronous read.

endmodule

`default_nettype wire

/* loop_counter.sv */
`default_nettype none

module loop_counter (
  input  logic       mclk,
  input  logic       arst_n,
  input  logic [7:0] loop_init,
  cond_if.cnt        cond,
  output logic       loop_zero
);

  import mic_pkg::*;

  logic [7:0] count_q;   // current loop count.
  logic [7:0] step;      // decrement size.
  logic       dec_only;  // decrement with no load or clear.

  assign step = cond.lcc[lcc_step2] ? 8'd2 : 8'd1;  // step2 halves the loop.
  assign dec_only = cond.lcc[lcc_dec] & ~cond.lcc[lcc_load] & ~cond.lcc[lcc_clear];

  // load, then clear, then decrement.
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (cond.lcc[lcc_load]) begin
      count_q <= loop_init;
    end else if (cond.lcc[lcc_clear]) begin
      count_q <= '0;
    end else if (cond.lcc[lcc_dec]) begin
      // saturate at zero instead of wrapping.
      count_q <= (count_q > step) ? count_q - step : 8'd0;
    end
  end

  assign loop_zero = (count_q == 8'd0);  // flag 15 of the test mux.

  // a decrement never wraps the count upwards.
  a_no_wrap : assert property (
    @(posedge mclk) disable iff (!arst_n)
      dec_only |=> count_q <= $past(count_q)
  );

endmodule

`default_nettype wire

/* mic_pkg.sv */
`default_nettype none

package mic_pkg;

  // ----------------------------------------
  // microword geometry.
  // ----------------------------------------
  localparam int uaddr_w = 8;   // control store address width.
  localparam int uword_w = 16;  // full microword.
  localparam int cond_w  = 12;  // condition field, bits 11..0 of the microword.
  localparam int flag_w  = 15;  // external test flags, loop zero sits above them.

  // sequencer opcode, microword bits 15..14. bits 13..12 are spare.
  // an all-zero word must decode as op_next.
  typedef enum logic [1:0] {
    op_next   = 2'b00,  // upc + 1.
    op_jump   = 2'b01,  // upc <= target address.
    op_branch = 2'b10,  // target address if the selected test is true.
    op_ldcond = 2'b11   // strobe cscond, upc + 1.
  } seq_op_e;

  // the 12-bit condition field is read two ways.
  // as condition bits on op_ldcond, and as a branch address on jump / branch.
  typedef union packed {
    struct packed {
      logic [3:0] lcc;       // loop counter control, 11..8.
      logic [3:0] tsel_raw;  // test select before lcs_n gating, 7..4.
      logic [3:0] fs;        // alu function select, 3..0.
    } cond;
    struct packed {
      logic [3:0] spare;     // unused in the address view.
      logic [7:0] addr;      // microprogram target.
    } target;
  } cond_field_u;

  // ----------------------------------------
  // loop counter control bits.
  // ----------------------------------------
  localparam int lcc_load  = 0;  // load from loop_init, highest priority.
  localparam int lcc_clear = 1;  // clear the count.
  localparam int lcc_dec   = 2;  // count down, saturating.
  localparam int lcc_step2 = 3;  // decrement by two instead of one.

endpackage

`default_nettype wire

/* mic_top.sv */
`default_nettype none

module mic_top (
  input  logic                        mclk,
  input  logic                        arst_n,
  input  logic                        lcs_n,
  input  logic [mic_pkg::flag_w-1:0]  flags,
  input  logic [7:0]                  loop_init,
  output logic [mic_pkg::uaddr_w-1:0] upc,
  output logic [3:0]                  alu_fs,
  output logic                        acond_n,
  output logic                        loop_zero
);

  import mic_pkg::*;

  logic [uword_w-1:0] uword;     // current microword.
  cond_field_u        cs_field;  // low 12 bits of it.
  logic               cscond;    // condition load strobe.

  cond_if cond_bus ();

  // ----------------------------------------
  // microprogram path.
  // ----------------------------------------
  control_store u_store (
    .upc   (upc),
    .uword (uword)
  );

  micro_seq u_seq (
    .mclk      (mclk),
    .arst_n    (arst_n),
    .uword     (uword),
    .flags     (flags),
    .loop_zero (loop_zero),
    .cond      (cond_bus.seq),
    .upc       (upc),
    .cs_field  (cs_field),
    .cscond    (cscond)
  );

  // condition state.
  cond_reg u_cond (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .cs_field (cs_field),
    .cscond   (cscond),
    .lcs_n    (lcs_n),
    .cond     (cond_bus.src)
  );

  loop_counter u_loop (
    .mclk      (mclk),
    .arst_n    (arst_n),
    .loop_init (loop_init),
    .cond      (cond_bus.cnt),
    .loop_zero (loop_zero)
  );

  assign alu_fs  = cond_bus.fs;       // to the alu, outside this slice.
  assign acond_n = cond_bus.acond_n;

endmodule

`default_nettype wire

/* micro_seq.sv */
`default_nettype none

module micro_seq (
  input  logic                          mclk,
  input  logic                          arst_n,
  input  logic [mic_pkg::uword_w-1:0]   uword,
  input  logic [mic_pkg::flag_w-1:0]    flags,
  input  logic                          loop_zero,
  cond_if.seq                           cond,
  output logic [mic_pkg::uaddr_w-1:0]   upc,
  output mic_pkg::cond_field_u          cs_field,
  output logic                          cscond
);

  import mic_pkg::*;

  seq_op_e            op;        // current opcode.
  logic [flag_w:0]    test_vec;  // flags with loop zero on top.
  logic               test_sel;  // flag picked by tsel.
  logic               test_ok;   // after the acond inversion.
  logic [uaddr_w-1:0] upc_inc;   // sequential address.
  logic [uaddr_w-1:0] upc_d;

  // ----------------------------------------
  // microword decode.
  // ----------------------------------------
  assign op       = seq_op_e'(uword[uword_w-1 -: 2]);
  assign cs_field = uword[cond_w-1:0];  // same bits, cond or target view.
  assign cscond   = (op == op_ldcond);  // one cycle per ldcond word.

  // ----------------------------------------
  // condition test mux.
  // ----------------------------------------
  assign test_vec = {loop_zero, flags};   // index 15 is loop zero.
  assign test_sel = test_vec[cond.tsel];
  assign test_ok  = test_sel ^ ~cond.acond_n;  // acond_n low inverts.

  // next address.
  assign upc_inc = upc + 1'b1;

  always_comb begin
    unique case (op)
      op_jump:   upc_d = cs_field.target.addr;
      op_branch: upc_d = test_ok ? cs_field.target.addr : upc_inc;
      default:   upc_d = upc_inc;  // op_next and op_ldcond.
    endcase
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      upc <= '0;
    end else begin
      upc <= upc_d;  // one microword per cycle.
    end
  end

  // ----------------------------------------
  // checks.
  // ----------------------------------------
  // a cscond cycle never redirects the sequencer.
  a_cscond_ldcond : assert property (
    @(posedge mclk) disable iff (!arst_n)
      cscond |=> (upc == $past(upc) + 8'd1)
  );

endmodule

`default_nettype wire

/* project.f */
mic_pkg.sv
cond_if.sv
cond_reg.sv
loop_counter.sv
micro_seq.sv
control_store.sv
mic_top.sv
tb_mic.sv

/* tb_mic.sv */
`default_nettype none

module tb_mic;

  timeunit 1ns;
  timeprecision 1ps;

  import mic_pkg::*;

  localparam int period       = 100;   // mclk period in ns.
  localparam int reset_cycles = 16;
  localparam int n_cycles     = 2000;  // compared cycles after reset.

  // model state, as the slice holds it.
  typedef struct packed {
    logic [uaddr_w-1:0] upc;
    cond_field_u        field;  // latched condition bits.
    logic [7:0]         count;  // loop count.
  } model_t;

  typedef struct packed {
    logic [uaddr_w-1:0] upc;
    logic [3:0]         fs;
    logic               acond_n;
    logic               loop_zero;
    model_t             nxt;    // state after the coming edge.
  } expect_t;

  logic               mclk = 1'b0;
  logic               arst_n = 1'b0;
  logic               lcs_n = 1'b0;
  logic [flag_w-1:0]  flags = '0;
  logic [7:0]         loop_init = '0;
  logic [uaddr_w-1:0] upc;
  logic [3:0]         alu_fs;
  logic               acond_n;
  logic               loop_zero;

  logic [uword_w-1:0] ref_rom [256];  // own copy of the microprogram.
  logic [31:0]        lfsr_q = 32'h157;
  model_t             model = '0;
  expect_t            exp_q;
  int                 checks_done = 0;

  mic_top i_mic_top (
    .mclk      (mclk),
    .arst_n    (arst_n),
    .lcs_n     (lcs_n),
    .flags     (flags),
    .loop_init (loop_init),
    .upc       (upc),
    .alu_fs    (alu_fs),
    .acond_n   (acond_n),
    .loop_zero (loop_zero)
  );

  always #(period / 2) mclk = ~mclk;  // 100 ns clock.

  initial begin
    for (int a = 0; a < 256; a++) begin
      ref_rom[a] = '0;  // unlisted words run as next.
    end
    $readmemh("ucode.hex", ref_rom);
  end

  // ----------------------------------------
  // random source and failure exit.
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
  endfunction

  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit.
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  // ----------------------------------------
  // reference model.
  // ----------------------------------------
  function automatic expect_t predict_cycle(input model_t s, input logic [flag_w-1:0] fl,
                                            input logic ls_n, input logic [7:0] init);
    expect_t     e;
    logic [15:0] w;
    cond_field_u f;
    logic [3:0]  ts;
    logic [3:0]  lc;
    logic [15:0] tests;
    logic        hit;
    logic [7:0]  dec;
    w = ref_rom[s.upc];
    f = cond_field_u'(w[11:0]);
    lc = s.field.cond.lcc;
    // test select, gated by lcs_n.
    ts[3] = !(ls_n && s.field.cond.tsel_raw[3]);
    ts[2:0] = ls_n ? s.field.cond.tsel_raw[2:0] : 3'b000;
    e.acond_n = !(ts[3] && ((ts[2] != ts[1]) || (ts[1] && !ts[0])));
    e.upc = s.upc;
    e.fs = s.field.cond.fs;
    e.loop_zero = (s.count == 8'd0);
    tests = {e.loop_zero, fl};  // loop zero is test 15.
    hit = e.acond_n ? tests[ts] : !tests[ts];
    e.nxt = s;
    case (seq_op_e'(w[15:14]))
      op_jump:   e.nxt.upc = f.target.addr;
      op_branch: e.nxt.upc = hit ? f.target.addr : s.upc + 8'd1;
      default:   e.nxt.upc = s.upc + 8'd1;
    endcase
    if (seq_op_e'(w[15:14]) == op_ldcond) begin
      e.nxt.field = f;  // visible after this edge only.
    end
    if (lc[lcc_load]) begin
      e.nxt.count = init;
    end else if (lc[lcc_clear]) begin
      e.nxt.count = 8'd0;
    end else if (lc[lcc_dec]) begin
      dec = lc[lcc_step2] ? 8'd2 : 8'd1;
      e.nxt.count = (s.count < dec) ? 8'd0 : s.count - dec;  // stops at zero.
    end
    return e;
  endfunction

  // ----------------------------------------
  // compare tasks.
  // ----------------------------------------
  task automatic check_addr(input string name, input logic [uaddr_w-1:0] exp_v,
                            input logic [uaddr_w-1:0] got);
    if (got !== exp_v) begin
      $display("ERR %0d ns %s expected %02h actual %02h", $time, name, exp_v, got);
      abort_run("upc mismatch");
    end
  endtask

  task automatic check_fs(input string name, input logic [3:0] exp_v, input logic [3:0] got);
    if (got !== exp_v) begin
      $display("ERR %0d ns %s expected %0h actual %0h", $time, name, exp_v, got);
      abort_run("alu function select mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic got);
    if (got !== exp_v) begin
      $display("ERR %0d ns %s expected %b actual %b", $time, name, exp_v, got);
      abort_run("flag mismatch");
    end
  endtask

  task automatic check_field(input string name, input cond_field_u exp_v,
                             input cond_field_u got);
    if (got !== exp_v) begin
      $display("ERR %0d ns %s expected %03h actual %03h", $time, name, exp_v, got);
      abort_run("latched condition field mismatch");
    end
  endtask

  // the flops update later in this step, so pre-edge values are seen.
  always @(posedge mclk) begin
    if (arst_n) begin
      exp_q = predict_cycle(model, flags, lcs_n, loop_init);
      check_addr("upc", exp_q.upc, upc);
      check_fs("alu_fs", exp_q.fs, alu_fs);
      check_bit("acond_n", exp_q.acond_n, acond_n);
      check_bit("loop_zero", exp_q.loop_zero, loop_zero);
      check_field("field_q", model.field, i_mic_top.u_cond.field_q);
      model = exp_q.nxt;
      checks_done++;
    end
  end

  // ----------------------------------------
  // stimulus.
  // ----------------------------------------
  task automatic drive_inputs();
    logic [31:0] r;
    if (model.upc == '0) begin
      random_bits(1, r);  // lcs_n holds for one pass of the program.
      lcs_n = r[0];
    end
    random_bits(flag_w, r);
    flags = r[flag_w-1:0];
    random_bits(5, r);
    loop_init = {3'b000, r[4:0]};  // short loops.
  endtask

  initial begin
    arst_n = 1'b0;
    lcs_n = 1'b0;
    flags = '0;
    loop_init = '0;
    repeat (reset_cycles) @(posedge mclk);
    for (int i = 0; i < n_cycles; i++) begin
      @(negedge mclk);
      arst_n = 1'b1;
      drive_inputs();
    end
    @(posedge mclk);
    @(negedge mclk);
    if (checks_done == n_cycles) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("not every cycle was compared");
    end
  end

  initial begin
    #(longint'(reset_cycles + n_cycles + 20) * period);
    abort_run("timeout, the run did not finish in time");
  end

endmodule

`default_nettype wire

/* ucode.hex */
// one 16-bit microword per line from address 00, with the opcode in bits 15..14
// and the condition field or branch target in bits 11..0.
C003 // 00 ldcond, fs 3, tsel 0, lcc idle.
0A55 // 01 next, field bits must not load.
4004 // 02 jump over 03.
0000 // 03 skipped.
C096 // 04 ldcond, tsel 9, fs 6.
8009 // 05 branch to 09.
C067 // 06 ldcond, tsel 6 inverts with lcs_n high.
800A // 07 branch to 0a.
0000 // 08 next.
0000 // 09 next.
C028 // 0a ldcond, tsel 2 inverts with lcs_n high.
800D // 0b branch to 0d.
0000 // 0c next.
C0B9 // 0d ldcond, tsel b.
8010 // 0e branch to 10.
0000 // 0f next.
C17A // 10 ldcond, lcc load, tsel 7 picks loop zero.
0000 // 11 next, count reloads.
C47B // 12 ldcond, lcc decrement by one.
8016 // 13 branch out of the loop.
4013 // 14 jump back to 13.
0000 // 15 unused.
C17C // 16 ldcond, lcc load again.
CC7D // 17 ldcond, lcc decrement by two.
801A // 18 branch out of the loop.
4018 // 19 jump back to 18.
C2F1 // 1a ldcond, lcc clear, tsel f.
8000 // 1b branch to 00.
4000 // 1c jump to 00.
